/* gb_memory.f */
+incdir+include
logic/gb_mem_pkg.sv
logic/gb_byte_ram.sv
logic/gb_interrupt_regs.sv
logic/gb_mmu.sv
logic/gb_memory_top.sv
dv/gb_memory_tb.sv

/* Bender.yml */
package:
  name: gb_memory

export_include_dirs:
  - include

sources:
  - files:
      - logic/gb_mem_pkg.sv
      - logic/gb_byte_ram.sv
      - logic/gb_interrupt_regs.sv
      - logic/gb_mmu.sv
      - logic/gb_memory_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/gb_memory_tb.sv

/* dv/gb_memory_vectors.txt */
# op test addr data expected, all hex except the decimal test number
# data is the write byte, the irq bits, or a cycle limit for WAIT, which expects busy cycles
W 1 C000 12 00
R 1 C000 00 12
W 1 E005 34 00
R 1 C005 00 34
W 1 D123 56 00
R 1 F123 00 56
W 1 FDFF 9A 00
R 1 DDFF 00 9A
W 1 8000 AB 00
R 1 8000 00 AB
W 1 9FFF CD 00
R 1 9FFF 00 CD
W 1 FE00 11 00
R 1 FE00 00 11
W 1 FE9F 22 00
R 1 FE9F 00 22
W 1 FF80 33 00
R 1 FF80 00 33
W 1 FFFE 44 00
R 1 FFFE 00 44
R 2 0000 00 00
R 2 1234 00 26
R 2 7FFF 00 80
R 2 4ABC 00 F6
R 2 A000 00 A0
R 2 BFFF 00 40
W 2 2000 05 00
W 2 A010 5A 00
R 2 FEA0 00 FF
R 2 FEFF 00 FF
R 2 FF01 00 FF
R 2 FF40 00 FF
R 2 FF7F 00 FF
R 3 FF0F 00 E0
W 3 FF0F FF 00
R 3 FF0F 00 FF
W 3 FF0F 00 00
R 3 FF0F 00 E0
IRQ 3 0000 05 00
R 3 FF0F 00 E5
IRQ 3 0000 12 00
R 3 FF0F 00 F7
W 3 FFFF A5 00
R 3 FFFF 00 A5
W 4 FF46 C1 00
WAIT 4 0000 00C8 00A0
R 4 FF46 00 C1
W 5 C010 11 00
R 5 C010 00 11
W 5 FF46 40 00
R 5 C010 00 FF
W 5 C010 77 00
W 5 FF46 12 00
W 5 FF90 3C 00
R 5 FF90 00 3C
WAIT 5 0000 00C8 009B
R 5 C010 00 11
R 5 FF46 00 40

/* dv/gb_memory_tb.sv */
`include "gb_consts.svh"

module gb_memory_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic reset;
  gb_mem_pkg::addr_t cpu_addr;
  gb_mem_pkg::byte_t cpu_wdata;
  logic cpu_read_en;
  logic cpu_write_en;
  gb_mem_pkg::byte_t cpu_rdata;
  gb_mem_pkg::addr_t cart_addr;
  gb_mem_pkg::byte_t cart_wdata;
  logic cart_read_en;
  logic cart_write_en;
  gb_mem_pkg::byte_t cart_rdata;
  logic [`GB_IRQ_COUNT-1:0] irq_request;
  logic [`GB_IRQ_COUNT-1:0] irq_flags;
  gb_mem_pkg::byte_t irq_enable;
  logic dma_busy;

  int vec_test [128];
  logic [31:0] vec_op [128];
  logic [15:0] vec_addr [128];
  logic [15:0] vec_data [128];
  logic [15:0] vec_exp [128];
  int vec_count;

  gb_mem_pkg::byte_t shadow [`GB_DMA_LENGTH];
  gb_mem_pkg::addr_t last_cart_addr;
  gb_mem_pkg::byte_t last_cart_data;
  gb_mem_pkg::addr_t exp_cart_addr;
  gb_mem_pkg::byte_t exp_cart_data;
  logic [`GB_IRQ_COUNT-1:0] if_model;
  gb_mem_pkg::byte_t ie_model;
  gb_mem_pkg::byte_t dma_page_model;
  gb_mem_pkg::target_e seen_target;
  int errors;
  int checks;
  int test_errors;
  int test_checks;
  int seed;
  int cycle_count;
  int cycle_limit = 100000;
  int dma_end_cycle;
  logic load_ok;

  gb_memory_top UUT (
    .clk           (clk),
    .reset         (reset),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_read_en   (cpu_read_en),
    .cpu_write_en  (cpu_write_en),
    .cpu_rdata     (cpu_rdata),
    .cart_addr     (cart_addr),
    .cart_wdata    (cart_wdata),
    .cart_read_en  (cart_read_en),
    .cart_write_en (cart_write_en),
    .cart_rdata    (cart_rdata),
    .irq_request   (irq_request),
    .irq_flags     (irq_flags),
    .irq_enable    (irq_enable),
    .dma_busy      (dma_busy)
  );

  // Cartridge answers every address with its two bytes XORed
  function automatic gb_mem_pkg::byte_t cart_byte(gb_mem_pkg::addr_t a);
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic logic is_cart(gb_mem_pkg::addr_t a);
    return (a <= `GB_ROM_END) || (a >= `GB_XRAM_START && a <= `GB_XRAM_END);
  endfunction

  assign cart_rdata = cart_byte(cart_addr);
  assign seen_target = UUT.mmu.cpu_target;

  always @(posedge clk) begin
    if (cart_write_en) begin
      last_cart_addr <= cart_addr;
      last_cart_data <= cart_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    errors++;
    $display("** Error at %0t: %s expected %h, got %h (cpu_addr %h, target %s)",
             $time, name, expected, actual, cpu_addr, seen_target.name());
  endtask

  task automatic drive_bus(input gb_mem_pkg::addr_t a, input gb_mem_pkg::byte_t d,
                           input logic rd, input logic wr,
                           input logic [`GB_IRQ_COUNT-1:0] irq);
    @(posedge clk);
    cpu_addr <= a;
    cpu_wdata <= d;
    cpu_read_en <= rd;
    cpu_write_en <= wr;
    irq_request <= irq;
  endtask

  task automatic do_read(input gb_mem_pkg::addr_t a, input gb_mem_pkg::byte_t expected);
    logic exp_rd;
    drive_bus(a, 8'h00, 1'b1, 1'b0, '0);
    @(negedge clk);
    // A running transfer owns the cartridge port
    if (cycle_count <= dma_end_cycle) begin
      exp_rd = is_cart({dma_page_model, 8'h00});
    end else begin
      exp_rd = is_cart(a);
    end
    checks++;
    if (cpu_rdata !== expected) report_mismatch("cpu_rdata", expected, cpu_rdata);
    checks++;
    if (cart_read_en !== exp_rd) report_mismatch("cart_read_en", exp_rd, cart_read_en);
  endtask

  task automatic do_write(input gb_mem_pkg::addr_t a, input gb_mem_pkg::byte_t d);
    drive_bus(a, d, 1'b0, 1'b1, '0);
    @(negedge clk);
    if (is_cart(a)) begin
      checks++;
      if (cart_write_en !== 1'b1 || cart_addr !== a || cart_wdata !== d) begin
        errors++;
        $display("Cartridge write of %h to %h did not appear on the cart port", d, a);
      end
      exp_cart_addr = a;
      exp_cart_data = d;
    end
    if (a == `GB_IF_ADDR) if_model = d[`GB_IRQ_COUNT-1:0];
    if (a == `GB_IE_ADDR) ie_model = d;
    // A DMA register write only lands while no transfer runs
    if (a == `GB_DMA_ADDR && cycle_count > dma_end_cycle) begin
      dma_page_model = d;
      dma_end_cycle = cycle_count + `GB_DMA_LENGTH;
    end
  endtask

  task automatic wait_dma(input int limit, input int expected_busy);
    int busy_cycles;
    logic done;
    busy_cycles = 0;
    done = 1'b0;
    while (!done && busy_cycles < limit) begin
      drive_bus(cpu_addr, 8'h00, 1'b0, 1'b0, '0);
      @(negedge clk);
      if (dma_busy) busy_cycles++;
      else done = 1'b1;
    end
    checks++;
    if (!done) begin
      errors++;
      $display("dma_busy was still high after %0d cycles", limit);
    end else if (busy_cycles != expected_busy) begin
      report_mismatch("dma_busy cycles", expected_busy, busy_cycles);
    end
  endtask

  task automatic run_vectors(input int test_num);
    for (int i = 0; i < vec_count; i++) begin
      if (vec_test[i] == test_num) begin
        case (vec_op[i])
          "W": do_write(vec_addr[i], vec_data[i][7:0]);
          "R": do_read(vec_addr[i], vec_exp[i][7:0]);
          "IRQ": begin
            drive_bus(cpu_addr, 8'h00, 1'b0, 1'b0, vec_data[i][`GB_IRQ_COUNT-1:0]);
            if_model = if_model | vec_data[i][`GB_IRQ_COUNT-1:0];
          end
          "WAIT": wait_dma(vec_data[i], vec_exp[i]);
          default: begin
            errors++;
            $display("Vector %0d has an unknown opcode", i);
          end
        endcase
      end
    end
  endtask

  task automatic load_vectors(output logic ok);
    int fd;
    int n;
    int total;
    logic [31:0] tok;
    logic [8*128-1:0] rest;
    ok = 1'b0;
    vec_count = 0;
    // Reset, random fill and two OAM sweeps are driven outside the file
    total = 2 + 3 * `GB_DMA_LENGTH;
    fd = $fopen("dv/gb_memory_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        tok = '0;
        n = $fscanf(fd, "%s", tok);
        if (n == 1 && tok == "#") begin
          n = $fgets(rest, fd);
        end else if (n == 1) begin
          vec_op[vec_count] = tok;
          n = $fscanf(fd, "%d %h %h %h", vec_test[vec_count], vec_addr[vec_count],
                      vec_data[vec_count], vec_exp[vec_count]);
          total += (tok == "WAIT") ? int'(vec_data[vec_count]) : 1;
          vec_count++;
        end
      end
      $fclose(fd);
      cycle_limit = 2 * total + 200;
    end
  endtask

  task automatic start_test();
    test_errors = errors;
    test_checks = checks;
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             checks - test_checks, errors - test_errors);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    reset = 1'b1;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_read_en = 1'b0;
    cpu_write_en = 1'b0;
    irq_request = '0;
    errors = 0;
    checks = 0;
    seed = 59391;
    if_model = '0;
    ie_model = 8'h00;
    dma_page_model = 8'h00;
    dma_end_cycle = 0;
    exp_cart_addr = '0;
    exp_cart_data = '0;
    load_vectors(load_ok);
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    if (!load_ok) begin
      errors++;
      $display("Could not open the vector file dv/gb_memory_vectors.txt");
    end else begin
      start_test();
      run_vectors(1);
      end_test(1, "memory read-back and echo");

      start_test();
      run_vectors(2);
      checks++;
      if (last_cart_addr !== exp_cart_addr) begin
        report_mismatch("last cart_addr", exp_cart_addr, last_cart_addr);
      end
      checks++;
      if (last_cart_data !== exp_cart_data) begin
        report_mismatch("last cart_wdata", exp_cart_data, last_cart_data);
      end
      end_test(2, "cartridge and open bus");

      start_test();
      run_vectors(3);
      checks++;
      if (irq_flags !== if_model) report_mismatch("irq_flags", if_model, irq_flags);
      checks++;
      if (irq_enable !== ie_model) report_mismatch("irq_enable", ie_model, irq_enable);
      end_test(3, "interrupt registers");

      start_test();
      checks++;
      if (dma_busy !== 1'b0) report_mismatch("dma_busy", 1'b0, dma_busy);
      for (int k = 0; k < `GB_DMA_LENGTH; k++) begin
        shadow[k] = 8'($random(seed));
        do_write(16'hC100 + 16'(k), shadow[k]);
      end
      run_vectors(4);
      for (int k = 0; k < `GB_DMA_LENGTH; k++) begin
        do_read(`GB_OAM_START + 16'(k), shadow[k]);
      end
      end_test(4, "DMA from work RAM");

      start_test();
      run_vectors(5);
      for (int k = 0; k < `GB_DMA_LENGTH; k++) begin
        do_read(`GB_OAM_START + 16'(k), cart_byte({dma_page_model, 8'(k)}));
      end
      end_test(5, "DMA from cartridge");
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* logic/gb_memory_top.sv */
`include "gb_consts.svh"

module gb_memory_top (
  input  logic                       clk,
  input  logic                       reset,

  input  gb_mem_pkg::addr_t          cpu_addr,
  input  gb_mem_pkg::byte_t          cpu_wdata,
  input  logic                       cpu_read_en,
  input  logic                       cpu_write_en,
  output gb_mem_pkg::byte_t          cpu_rdata,

  output gb_mem_pkg::addr_t          cart_addr,
  output gb_mem_pkg::byte_t          cart_wdata,
  output logic                       cart_read_en,
  output logic                       cart_write_en,
  input  gb_mem_pkg::byte_t          cart_rdata,

  input  logic [`GB_IRQ_COUNT-1:0]   irq_request,
  output logic [`GB_IRQ_COUNT-1:0]   irq_flags,
  output gb_mem_pkg::byte_t          irq_enable,
  output logic                       dma_busy
);

  logic [$clog2(`GB_VRAM_SIZE)-1:0] vram_addr;
  gb_mem_pkg::byte_t vram_wdata;
  logic vram_read_en;
  logic vram_write_en;
  gb_mem_pkg::byte_t vram_rdata;

  logic [$clog2(`GB_WRAM_SIZE)-1:0] wram_addr;
  gb_mem_pkg::byte_t wram_wdata;
  logic wram_read_en;
  logic wram_write_en;
  gb_mem_pkg::byte_t wram_rdata;

  logic [$clog2(`GB_OAM_SIZE)-1:0] oam_addr;
  gb_mem_pkg::byte_t oam_wdata;
  logic oam_read_en;
  logic oam_write_en;
  gb_mem_pkg::byte_t oam_rdata;

  logic [$clog2(`GB_HRAM_SIZE)-1:0] hram_addr;
  gb_mem_pkg::byte_t hram_wdata;
  logic hram_read_en;
  logic hram_write_en;
  gb_mem_pkg::byte_t hram_rdata;

  logic irq_addr;
  gb_mem_pkg::byte_t irq_wdata;
  logic irq_read_en;
  logic irq_write_en;
  gb_mem_pkg::byte_t irq_rdata;

  gb_mmu mmu (
    .clk           (clk),
    .reset         (reset),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_read_en   (cpu_read_en),
    .cpu_write_en  (cpu_write_en),
    .cpu_rdata     (cpu_rdata),
    .cart_addr     (cart_addr),
    .cart_wdata    (cart_wdata),
    .cart_read_en  (cart_read_en),
    .cart_write_en (cart_write_en),
    .cart_rdata    (cart_rdata),
    .vram_addr     (vram_addr),
    .vram_wdata    (vram_wdata),
    .vram_read_en  (vram_read_en),
    .vram_write_en (vram_write_en),
    .vram_rdata    (vram_rdata),
    .wram_addr     (wram_addr),
    .wram_wdata    (wram_wdata),
    .wram_read_en  (wram_read_en),
    .wram_write_en (wram_write_en),
    .wram_rdata    (wram_rdata),
    .oam_addr      (oam_addr),
    .oam_wdata     (oam_wdata),
    .oam_read_en   (oam_read_en),
    .oam_write_en  (oam_write_en),
    .oam_rdata     (oam_rdata),
    .hram_addr     (hram_addr),
    .hram_wdata    (hram_wdata),
    .hram_read_en  (hram_read_en),
    .hram_write_en (hram_write_en),
    .hram_rdata    (hram_rdata),
    .irq_addr      (irq_addr),
    .irq_wdata     (irq_wdata),
    .irq_read_en   (irq_read_en),
    .irq_write_en  (irq_write_en),
    .irq_rdata     (irq_rdata),
    .dma_busy      (dma_busy)
  );

  gb_byte_ram #(.depth(`GB_VRAM_SIZE)) vram_mem (
    .clk      (clk),
    .addr     (vram_addr),
    .wdata    (vram_wdata),
    .read_en  (vram_read_en),
    .write_en (vram_write_en),
    .rdata    (vram_rdata)
  );

  gb_byte_ram #(.depth(`GB_WRAM_SIZE)) wram_mem (
    .clk      (clk),
    .addr     (wram_addr),
    .wdata    (wram_wdata),
    .read_en  (wram_read_en),
    .write_en (wram_write_en),
    .rdata    (wram_rdata)
  );

  gb_byte_ram #(.depth(`GB_OAM_SIZE)) oam_mem (
    .clk      (clk),
    .addr     (oam_addr),
    .wdata    (oam_wdata),
    .read_en  (oam_read_en),
    .write_en (oam_write_en),
    .rdata    (oam_rdata)
  );

  gb_byte_ram #(.depth(`GB_HRAM_SIZE)) hram_mem (
    .clk      (clk),
    .addr     (hram_addr),
    .wdata    (hram_wdata),
    .read_en  (hram_read_en),
    .write_en (hram_write_en),
    .rdata    (hram_rdata)
  );

  gb_interrupt_regs irq_regs (
    .clk         (clk),
    .reset       (reset),
    .addr        (irq_addr),
    .wdata       (irq_wdata),
    .read_en     (irq_read_en),
    .write_en    (irq_write_en),
    .irq_request (irq_request),
    .rdata       (irq_rdata),
    .irq_flags   (irq_flags),
    .irq_enable  (irq_enable)
  );

endmodule

/* logic/gb_mmu.sv */
`include "gb_consts.svh"

module gb_mmu (
  input  logic                                clk,
  input  logic                                reset,

  input  gb_mem_pkg::addr_t                   cpu_addr,
  input  gb_mem_pkg::byte_t                   cpu_wdata,
  input  logic                                cpu_read_en,
  input  logic                                cpu_write_en,
  output gb_mem_pkg::byte_t                   cpu_rdata,

  output gb_mem_pkg::addr_t                   cart_addr,
  output gb_mem_pkg::byte_t                   cart_wdata,
  output logic                                cart_read_en,
  output logic                                cart_write_en,
  input  gb_mem_pkg::byte_t                   cart_rdata,

  output logic [$clog2(`GB_VRAM_SIZE)-1:0]    vram_addr,
  output gb_mem_pkg::byte_t                   vram_wdata,
  output logic                                vram_read_en,
  output logic                                vram_write_en,
  input  gb_mem_pkg::byte_t                   vram_rdata,

  output logic [$clog2(`GB_WRAM_SIZE)-1:0]    wram_addr,
  output gb_mem_pkg::byte_t                   wram_wdata,
  output logic                                wram_read_en,
  output logic                                wram_write_en,
  input  gb_mem_pkg::byte_t                   wram_rdata,

  output logic [$clog2(`GB_OAM_SIZE)-1:0]     oam_addr,
  output gb_mem_pkg::byte_t                   oam_wdata,
  output logic                                oam_read_en,
  output logic                                oam_write_en,
  input  gb_mem_pkg::byte_t                   oam_rdata,

  output logic [$clog2(`GB_HRAM_SIZE)-1:0]    hram_addr,
  output gb_mem_pkg::byte_t                   hram_wdata,
  output logic                                hram_read_en,
  output logic                                hram_write_en,
  input  gb_mem_pkg::byte_t                   hram_rdata,

  output logic                                irq_addr,
  output gb_mem_pkg::byte_t                   irq_wdata,
  output logic                                irq_read_en,
  output logic                                irq_write_en,
  input  gb_mem_pkg::byte_t                   irq_rdata,

  output logic                                dma_busy
);

  gb_mem_pkg::target_e cpu_target;
  gb_mem_pkg::byte_t dma_page;
  gb_mem_pkg::byte_t dma_count;
  logic dma_active;
  gb_mem_pkg::addr_t dma_src;
  gb_mem_pkg::byte_t dma_byte;
  logic dma_from_cart;
  logic dma_from_wram;
  gb_mem_pkg::addr_t wram_fold;
  gb_mem_pkg::addr_t vram_off;
  gb_mem_pkg::addr_t wram_off;
  gb_mem_pkg::addr_t oam_off;
  gb_mem_pkg::addr_t hram_off;
  gb_mem_pkg::addr_t dma_wram_off;

  always_comb begin
    if (cpu_addr inside {[`GB_ROM_START:`GB_ROM_END], [`GB_XRAM_START:`GB_XRAM_END]}) begin
      cpu_target = gb_mem_pkg::cart;
    end else if (cpu_addr inside {[`GB_VRAM_START:`GB_VRAM_END]}) begin
      cpu_target = gb_mem_pkg::vram;
    end else if (cpu_addr inside {[`GB_WRAM_START:`GB_ECHO_END]}) begin
      cpu_target = gb_mem_pkg::wram;
    end else if (cpu_addr inside {[`GB_OAM_START:`GB_OAM_END]}) begin
      cpu_target = gb_mem_pkg::oam;
    end else if (cpu_addr inside {[`GB_UNUSABLE_START:`GB_UNUSABLE_END]}) begin
      cpu_target = gb_mem_pkg::unusable;
    end else if (cpu_addr == `GB_IF_ADDR || cpu_addr == `GB_IE_ADDR) begin
      cpu_target = gb_mem_pkg::irq;
    end else if (cpu_addr == `GB_DMA_ADDR) begin
      cpu_target = gb_mem_pkg::dma_reg;
    end else if (cpu_addr inside {[`GB_HRAM_START:`GB_HRAM_END]}) begin
      cpu_target = gb_mem_pkg::hram;
    end else begin
      cpu_target = gb_mem_pkg::unmapped;
    end
  end

  // Echo region lands on work RAM
  assign wram_fold = (cpu_addr >= `GB_ECHO_START) ?
                     cpu_addr - (`GB_ECHO_START - `GB_WRAM_START) : cpu_addr;
  assign vram_off  = cpu_addr - `GB_VRAM_START;
  assign wram_off  = wram_fold - `GB_WRAM_START;
  assign oam_off   = cpu_addr - `GB_OAM_START;
  assign hram_off  = cpu_addr - `GB_HRAM_START;

  // DMA source side
  assign dma_src       = {dma_page, dma_count};
  assign dma_wram_off  = dma_src - `GB_WRAM_START;
  assign dma_from_cart = dma_active &&
      (dma_src inside {[`GB_ROM_START:`GB_ROM_END], [`GB_XRAM_START:`GB_XRAM_END]});
  assign dma_from_wram = dma_active && (dma_src inside {[`GB_WRAM_START:`GB_WRAM_END]});

  always_comb begin
    if (dma_from_cart) begin
      dma_byte = cart_rdata;
    end else if (dma_from_wram) begin
      dma_byte = wram_rdata;
    end else begin
      dma_byte = `GB_OPEN_BUS;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dma_page   <= 8'h00;
      dma_active <= 1'b0;
      dma_count  <= 8'h00;
    end else if (dma_active) begin
      if (dma_count == 8'(`GB_DMA_LENGTH - 1)) begin
        dma_active <= 1'b0;
      end
      dma_count <= dma_count + 8'd1;
    end else if (cpu_write_en && cpu_target == gb_mem_pkg::dma_reg) begin
      dma_page   <= cpu_wdata;
      dma_active <= 1'b1;
      dma_count  <= 8'h00;
    end
  end

  assign dma_busy = dma_active;

  assign cart_addr     = dma_active ? dma_src : cpu_addr;
  assign cart_wdata    = cpu_wdata;
  assign cart_read_en  = dma_active ? dma_from_cart :
                         cpu_read_en && cpu_target == gb_mem_pkg::cart;
  assign cart_write_en = !dma_active && cpu_write_en && cpu_target == gb_mem_pkg::cart;

  assign vram_addr     = vram_off[$bits(vram_addr)-1:0];
  assign vram_wdata    = cpu_wdata;
  assign vram_read_en  = !dma_active && cpu_read_en && cpu_target == gb_mem_pkg::vram;
  assign vram_write_en = !dma_active && cpu_write_en && cpu_target == gb_mem_pkg::vram;

  assign wram_addr     = dma_active ? dma_wram_off[$bits(wram_addr)-1:0] :
                         wram_off[$bits(wram_addr)-1:0];
  assign wram_wdata    = cpu_wdata;
  assign wram_read_en  = dma_active ? dma_from_wram :
                         cpu_read_en && cpu_target == gb_mem_pkg::wram;
  assign wram_write_en = !dma_active && cpu_write_en && cpu_target == gb_mem_pkg::wram;

  // OAM write port belongs to the DMA while a transfer runs
  assign oam_addr      = dma_active ? dma_count[$bits(oam_addr)-1:0] :
                         oam_off[$bits(oam_addr)-1:0];
  assign oam_wdata     = dma_active ? dma_byte : cpu_wdata;
  assign oam_read_en   = !dma_active && cpu_read_en && cpu_target == gb_mem_pkg::oam;
  assign oam_write_en  = dma_active || (cpu_write_en && cpu_target == gb_mem_pkg::oam);

  assign hram_addr     = hram_off[$bits(hram_addr)-1:0];
  assign hram_wdata    = cpu_wdata;
  assign hram_read_en  = cpu_read_en && cpu_target == gb_mem_pkg::hram;
  assign hram_write_en = cpu_write_en && cpu_target == gb_mem_pkg::hram;

  assign irq_addr      = cpu_addr == `GB_IE_ADDR;
  assign irq_wdata     = cpu_wdata;
  assign irq_read_en   = !dma_active && cpu_read_en && cpu_target == gb_mem_pkg::irq;
  assign irq_write_en  = !dma_active && cpu_write_en && cpu_target == gb_mem_pkg::irq;

  always_comb begin
    cpu_rdata = `GB_OPEN_BUS;
    if (cpu_read_en) begin
      if (cpu_target == gb_mem_pkg::hram) begin
        cpu_rdata = hram_rdata;
      end else if (!dma_active) begin
        case (cpu_target)
          gb_mem_pkg::cart:    cpu_rdata = cart_rdata;
          gb_mem_pkg::vram:    cpu_rdata = vram_rdata;
          gb_mem_pkg::wram:    cpu_rdata = wram_rdata;
          gb_mem_pkg::oam:     cpu_rdata = oam_rdata;
          gb_mem_pkg::irq:     cpu_rdata = irq_rdata;
          gb_mem_pkg::dma_reg: cpu_rdata = dma_page;
          default:             cpu_rdata = `GB_OPEN_BUS;
        endcase
      end
    end
  end

endmodule

/* logic/gb_interrupt_regs.sv */
`include "gb_consts.svh"

module gb_interrupt_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       addr,
  input  gb_mem_pkg::byte_t          wdata,
  input  logic                       read_en,
  input  logic                       write_en,
  input  logic [`GB_IRQ_COUNT-1:0]   irq_request,
  output gb_mem_pkg::byte_t          rdata,
  output logic [`GB_IRQ_COUNT-1:0]   irq_flags,
  output gb_mem_pkg::byte_t          irq_enable
);

  // addr low selects IF, addr high selects IE
  logic [`GB_IRQ_COUNT-1:0] if_q;
  gb_mem_pkg::byte_t ie_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      if_q <= '0;
      ie_q <= 8'h00;
    end else begin
      // CPU write wins over a request in the same cycle
      if (write_en && !addr) begin
        if_q <= wdata[`GB_IRQ_COUNT-1:0];
      end else begin
        if_q <= if_q | irq_request;
      end
      if (write_en && addr) begin
        ie_q <= wdata;
      end
    end
  end

  always_comb begin
    if (!read_en) begin
      rdata = `GB_OPEN_BUS;
    end else if (addr) begin
      rdata = ie_q;
    end else begin
      rdata = {{(8 - `GB_IRQ_COUNT){1'b1}}, if_q};
    end
  end

  assign irq_flags  = if_q;
  assign irq_enable = ie_q;

endmodule

/* logic/gb_byte_ram.sv */
module gb_byte_ram #(
  parameter int depth = 8192,
  localparam int addr_width = $clog2(depth)
) (
  input  logic                  clk,
  input  logic [addr_width-1:0] addr,
  input  gb_mem_pkg::byte_t     wdata,
  input  logic                  read_en,
  input  logic                  write_en,
  output gb_mem_pkg::byte_t     rdata
);

  gb_mem_pkg::byte_t mem [depth];
  logic in_range;

  // Depths that are not a power of two leave a hole at the top
  assign in_range = addr < depth;

  always_ff @(posedge clk) begin
    if (write_en && in_range) begin
      mem[addr] <= wdata;
    end
  end

  always_comb begin
    if (read_en && in_range) begin
      rdata = mem[addr];
    end else begin
      rdata = 8'hFF;
    end
  end

endmodule

/* logic/gb_mem_pkg.sv */
package gb_mem_pkg;

  typedef logic [15:0] addr_t;

  typedef logic [7:0] byte_t;

  // Decoded destination of a CPU access
  typedef enum logic [3:0] {
    cart,
    vram,
    wram,
    oam,
    hram,
    irq,
    dma_reg,
    unusable,
    unmapped
  } target_e;

endpackage

/* include/gb_consts.svh */
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

// Cartridge ROM and external RAM windows
`define GB_ROM_START       16'h0000
`define GB_ROM_END         16'h7FFF
`define GB_XRAM_START      16'hA000
`define GB_XRAM_END        16'hBFFF

`define GB_VRAM_START      16'h8000
`define GB_VRAM_END        16'h9FFF

// Echo mirrors the first 7.5K of work RAM
`define GB_WRAM_START      16'hC000
`define GB_WRAM_END        16'hDFFF
`define GB_ECHO_START      16'hE000
`define GB_ECHO_END        16'hFDFF

`define GB_OAM_START       16'hFE00
`define GB_OAM_END         16'hFE9F
`define GB_UNUSABLE_START  16'hFEA0
`define GB_UNUSABLE_END    16'hFEFF

`define GB_IF_ADDR         16'hFF0F
`define GB_DMA_ADDR        16'hFF46
`define GB_HRAM_START      16'hFF80
`define GB_HRAM_END        16'hFFFE
`define GB_IE_ADDR         16'hFFFF

// Memory depths in bytes
`define GB_VRAM_SIZE       8192
`define GB_WRAM_SIZE       8192
`define GB_OAM_SIZE        160
`define GB_HRAM_SIZE       127

`define GB_DMA_LENGTH      160
`define GB_IRQ_COUNT       5
`define GB_OPEN_BUS        8'hFF

`endif
